//--- list.f
logic/dino_pkg.sv
logic/dino_regs.sv
logic/game_fsm.sv
logic/dino_motion.sv
logic/obstacle_field.sv
logic/collision_check.sv
logic/dino_top.sv
tests/dino_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the dino testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f --top-module dino_tb -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vdino_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi
echo "Simulation finished cleanly"
exit 0

//--- tests/dino_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dino_tb import dino_pkg::*; ();

    logic        pclk;
    logic        rst;
    logic        vsync;
    logic        jump;
    logic        duck;
    logic        start;
    logic        pause;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        game_over;

    integer      seed;
    integer      rnd;
    logic [15:0] rd;
    speed_t      spd;      // Random speed under test
    int          obs_x;    // Predicted obstacle 0 column
    int          frames;
    int          y_exp;
    logic        landed;
    logic        ended;

    dino_top UUT (
        .pclk      (pclk),
        .rst       (rst),
        .vsync     (vsync),
        .jump      (jump),
        .duck      (duck),
        .start     (start),
        .pause     (pause),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .game_over (game_over)
    );

    initial begin
        pclk = 1'b0;
        forever #10 pclk = ~pclk;  // 50 MHz
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // One Wishbone classic transfer, exactly one ack expected
    task automatic bus_cycle(input logic we, input logic [2:0] adr,
                             input logic [15:0] wdat, output logic [15:0] rdat);
        int waited;
        waited = 0;
        @(posedge pclk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(posedge pclk);
            waited++;
        end while (!wb_rsp.ack && waited < 16);
        if (!wb_rsp.ack) begin
            abort_run($sformatf("No Wishbone ack for register %0d within 16 clocks", adr));
        end else begin
            rdat = wb_rsp.dat;
            wb_req <= '0;
            @(posedge pclk);
            if (wb_rsp.ack) begin
                abort_run($sformatf("Register %0d was acknowledged twice", adr));
            end
        end
    endtask

    task automatic read_reg(input logic [2:0] adr, output logic [15:0] dat);
        bus_cycle(1'b0, adr, 16'd0, dat);
    endtask

    task automatic write_reg(input logic [2:0] adr, input logic [15:0] dat);
        logic [15:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    // High for two clocks so the FSM sees one rising edge
    task automatic run_frame();
        @(posedge pclk);
        vsync <= 1'b1;
        @(posedge pclk);
        @(posedge pclk);
        vsync <= 1'b0;
        repeat (3) @(posedge pclk);
    endtask

    task automatic press_start();
        @(posedge pclk);
        start <= 1'b1;
        @(posedge pclk);
        start <= 1'b0;
    endtask

    task automatic press_pause();
        @(posedge pclk);
        pause <= 1'b1;
        @(posedge pclk);
        pause <= 1'b0;
    endtask

    // Height after a number of frames, jump held only in the first
    function automatic int jump_height(input int count);
        int y;
        int v;
        int i;
        y = GROUND_Y - DINO_H;
        v = 0;
        for (i = 1; i <= count; i++) begin
            if (y >= GROUND_Y - DINO_H) begin
                if (i == 1) begin
                    v = -JUMP_VEL;
                    y = y - JUMP_VEL;
                end
            end else if (y + v >= GROUND_Y - DINO_H) begin
                y = GROUND_Y - DINO_H;  // Lands
                v = 0;
            end else begin
                y = y + v;
                v = v + GRAVITY;
            end
        end
        return y;
    endfunction

    function automatic int obs_column(input int x0, input int count, input int speed,
                                      input int score);
        return x0 - count * (speed + score / 16);
    endfunction

    task automatic state_matches(input game_state_t got, input game_state_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: state %0d, expected %s", $time, got, exp.name()));
        end
    endtask

    task automatic coord_matches(input coord_t got, input coord_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic score_matches(input score_t got, input score_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: score is %0d, expected %0d", $time, got, exp));
        end
    endtask

    task automatic speed_matches(input speed_t got, input speed_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: speed is %0d, expected %0d", $time, got, exp));
        end
    endtask

    task automatic flag_matches(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    initial begin
        seed   = 32'h225;
        rst    = 1'b1;
        vsync  = 1'b0;
        jump   = 1'b0;
        duck   = 1'b0;
        start  = 1'b0;
        pause  = 1'b0;
        wb_req = '0;
        repeat (8) @(posedge pclk);
        rst <= 1'b0;

        // Reset values
        read_reg(REG_STATE, rd);
        state_matches(game_state_t'(rd[2:0]), ST_MENU);
        read_reg(REG_DINO_Y, rd);
        coord_matches(rd[9:0], coord_t'(GROUND_Y - DINO_H), "dino y");
        read_reg(REG_SCORE, rd);
        score_matches(rd[9:0], score_t'(0));
        read_reg(REG_SPEED, rd);
        speed_matches(rd[3:0], speed_t'(SPEED_DEFAULT));
        read_reg(REG_OBS0_X, rd);
        coord_matches(rd[9:0], coord_t'(START_X), "obstacle 0 column");
        flag_matches(game_over, 1'b0, "game_over");

        rnd = $random(seed);
        spd = speed_t'(1 + ((rnd & 32'h7fff_ffff) % 7));
        write_reg(REG_SPEED, {12'ha50, spd});  // Upper bits must be dropped
        read_reg(REG_SPEED, rd);
        speed_matches(rd[3:0], spd);

        press_start();
        read_reg(REG_STATE, rd);
        state_matches(game_state_t'(rd[2:0]), ST_RUN);
        repeat (5) run_frame();
        obs_x = obs_column(START_X, 5, int'(spd), 0);
        read_reg(REG_OBS0_X, rd);
        coord_matches(rd[9:0], coord_t'(obs_x), "obstacle 0 column");
        read_reg(REG_SCORE, rd);
        score_matches(rd[9:0], score_t'(0));

        frames = 0;
        landed = 1'b0;
        while (!landed && frames < 100) begin
            if (frames == 0) begin
                @(posedge pclk);
                jump <= 1'b1;
                run_frame();
                jump <= 1'b0;
            end else begin
                run_frame();
            end
            frames++;
            y_exp = jump_height(frames);
            read_reg(REG_DINO_Y, rd);
            coord_matches(rd[9:0], coord_t'(y_exp), "dino y");
            if (frames == 1) begin
                read_reg(REG_STATE, rd);
                flag_matches(rd[3], 1'b1, "airborne");
            end
            landed = (frames > 1) && (y_exp == GROUND_Y - DINO_H);
        end
        if (!landed) begin
            abort_run("The dinosaur did not land within 100 frames of the jump");
        end
        obs_x = obs_column(obs_x, frames, int'(spd), 0);

        press_pause();
        read_reg(REG_STATE, rd);
        state_matches(game_state_t'(rd[2:0]), ST_PAUSE);
        @(posedge pclk);
        jump <= 1'b1;  // Would lift a running dinosaur
        repeat (3) begin
            run_frame();
            read_reg(REG_DINO_Y, rd);
            coord_matches(rd[9:0], coord_t'(GROUND_Y - DINO_H), "dino y");
            read_reg(REG_OBS0_X, rd);
            coord_matches(rd[9:0], coord_t'(obs_x), "obstacle 0 column");
        end
        @(posedge pclk);
        jump <= 1'b0;
        press_pause();
        read_reg(REG_STATE, rd);
        state_matches(game_state_t'(rd[2:0]), ST_RUN);

        // Run idle into obstacle 0
        write_reg(REG_SPEED, 16'(SPEED_DEFAULT));
        ended  = 1'b0;
        frames = 0;
        while (!ended && frames < 200) begin
            run_frame();
            frames++;
            obs_x = obs_column(obs_x, 1, SPEED_DEFAULT, 0);
            read_reg(REG_STATE, rd);
            if (obs_x < DINO_X + DINO_W) begin
                state_matches(game_state_t'(rd[2:0]), ST_OVER);
                flag_matches(game_over, 1'b1, "game_over");
                ended = 1'b1;
            end else begin
                state_matches(game_state_t'(rd[2:0]), ST_RUN);
                flag_matches(game_over, 1'b0, "game_over");
            end
        end
        if (!ended) begin
            abort_run("The game did not end within 200 frames");
        end

        press_start();
        read_reg(REG_STATE, rd);
        state_matches(game_state_t'(rd[2:0]), ST_MENU);
        flag_matches(game_over, 1'b0, "game_over");

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/dino_top.sv
`timescale 1ns/1ps
`default_nettype none

module dino_top import dino_pkg::*; (
    input  wire          pclk,
    input  wire          rst,
    input  wire          vsync,
    input  wire          jump,
    input  wire          duck,
    input  wire          start,
    input  wire          pause,
    input  wire wb_req_t wb_req,
    output wire wb_rsp_t wb_rsp,
    output wire          game_over
);

    game_state_t state;
    speed_t      speed;
    dino_t       dino;
    obs_slots_t  slots;
    score_t      score;
    logic        frame_run;  // One clock per running frame
    logic        restart;
    logic        hit;

    dino_regs u_regs (
        .pclk   (pclk),
        .rst    (rst),
        .req    (wb_req),
        .rsp    (wb_rsp),
        .state  (state),
        .dino   (dino),
        .score  (score),
        .obs0_x (slots[0].x),
        .speed  (speed)
    );

    game_fsm u_fsm (
        .pclk      (pclk),
        .rst       (rst),
        .vsync     (vsync),
        .start     (start),
        .pause     (pause),
        .hit       (hit),
        .state     (state),
        .frame_run (frame_run),
        .restart   (restart),
        .game_over (game_over)
    );

    dino_motion u_motion (
        .pclk      (pclk),
        .rst       (rst),
        .frame_run (frame_run),
        .restart   (restart),
        .jump      (jump),
        .duck      (duck),
        .dino      (dino)
    );

    obstacle_field u_field (
        .pclk      (pclk),
        .rst       (rst),
        .frame_run (frame_run),
        .restart   (restart),
        .speed     (speed),
        .slots     (slots),
        .score     (score)
    );

    collision_check u_hit (
        .dino  (dino),
        .slots (slots),
        .hit   (hit)
    );

endmodule

`default_nettype wire

//--- logic/collision_check.sv
`timescale 1ns/1ps
`default_nettype none

module collision_check import dino_pkg::*; (
    input  wire dino_t      dino,
    input  wire obs_slots_t slots,
    output logic            hit
);

    xpos_t       dino_right;  // First column past the box
    logic [10:0] box_top;
    logic [10:0] box_bot;
    xpos_t       obs_w;
    logic        y_hit;

    assign dino_right = xpos_t'(DINO_X) + (dino.ducking ? xpos_t'(DUCK_W) : xpos_t'(DINO_W));
    assign box_top    = {1'b0, dino.y} + (dino.ducking ? 11'(DUCK_TOP_TRIM) : 11'd0);
    assign box_bot    = {1'b0, dino.y} + (dino.ducking ? 11'(DUCK_H) : 11'(DINO_H));

    always_comb begin
        hit   = 1'b0;
        obs_w = '0;
        y_hit = 1'b0;
        for (int i = 0; i < OBS_SLOTS; i++) begin
            case (slots[i].kind)
                SMALL: begin
                    obs_w = xpos_t'(CACTUS_S_W);
                    y_hit = box_bot > 11'(GROUND_Y - CACTUS_S_H);
                end
                BIG: begin
                    obs_w = xpos_t'(CACTUS_B_W);
                    y_hit = box_bot > 11'(GROUND_Y - CACTUS_B_H);
                end
                PTERO, PTERO2: begin
                    // Flying band, a crouched box passes under it
                    obs_w = xpos_t'(PTERO_W);
                    y_hit = (box_bot > 11'(GROUND_Y - PTERO_H - PTERO_LIFT)) &&
                            (box_top < 11'(GROUND_Y - PTERO_LIFT));
                end
                default: begin
                    obs_w = '0;
                    y_hit = 1'b0;
                end
            endcase
            if (slots[i].active && y_hit && (dino_right > slots[i].x) &&
                (xpos_t'(DINO_X) < slots[i].x + obs_w)) begin
                hit = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/obstacle_field.sv
`timescale 1ns/1ps
`default_nettype none

module obstacle_field import dino_pkg::*; (
    input  wire         pclk,
    input  wire         rst,
    input  wire         frame_run,
    input  wire         restart,
    input  wire speed_t speed,
    output obs_slots_t  slots,
    output score_t      score
);

    logic [9:0] lfsr;
    logic [8:0] spawn_off;  // Extra gap before the next spawn
    logic [1:0] last_idx;   // Most recently spawned slot
    logic [1:0] next_idx;
    xpos_t      step;
    xpos_t      spawn_lim;
    logic       spawn;
    obs_slots_t slots_n;
    score_t     score_n;

    function automatic obs_slots_t slots_init();
        obs_slots_t s;
        s           = '0;
        s[0].active = 1'b1;
        s[0].kind   = SMALL;
        s[0].x      = xpos_t'(START_X);
        return s;
    endfunction

    assign next_idx  = (last_idx == 2'(OBS_SLOTS - 1)) ? 2'd0 : last_idx + 2'd1;
    assign step      = xpos_t'({9'd0, speed}) + xpos_t'({7'd0, score[9:4]});  // Speeds up with score
    assign spawn_lim = xpos_t'(SCREEN_W - MIN_GAP) - xpos_t'({4'd0, spawn_off});
    assign spawn     = (slots[last_idx].x < spawn_lim) && !slots[next_idx].active;

    // Free running, x^10 + x^7 + 1
    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            lfsr <= 10'h001;
        end else begin
            lfsr <= {lfsr[8:0], lfsr[9] ^ lfsr[6]};
        end
    end

    always_comb begin
        slots_n = slots;
        score_n = score;
        for (int i = 0; i < OBS_SLOTS; i++) begin
            slots_n[i].x = slots[i].x - step;
            if (slots[i].active && slots[i].x < xpos_t'(RETIRE_X)) begin
                slots_n[i].active = 1'b0;  // Off the left edge
                score_n           = score_n + score_t'(1);
            end
        end
        if (spawn) begin
            slots_n[next_idx].active = 1'b1;
            slots_n[next_idx].kind   = obs_kind_t'(lfsr[9:8]);
            slots_n[next_idx].x      = xpos_t'(SPAWN_X);
        end
    end

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            slots     <= slots_init();
            score     <= '0;
            last_idx  <= 2'd0;
            spawn_off <= '0;
        end else if (restart) begin
            slots     <= slots_init();
            score     <= '0;
            last_idx  <= 2'd0;
            spawn_off <= '0;
        end else if (frame_run) begin
            slots <= slots_n;
            score <= score_n;
            if (spawn) begin
                last_idx  <= next_idx;
                spawn_off <= lfsr[8:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/dino_motion.sv
`timescale 1ns/1ps
`default_nettype none

module dino_motion import dino_pkg::*; (
    input  wire   pclk,
    input  wire   rst,
    input  wire   frame_run,
    input  wire   restart,
    input  wire   jump,
    input  wire   duck,
    output dino_t dino
);

    vel_t               vel;       // Negative is upward
    logic               on_ground;
    logic signed [11:0] air_y;     // Height after one frame of flight

    assign on_ground = dino.y >= coord_t'(GROUND_Y - DINO_H);
    assign air_y     = $signed({2'b00, dino.y}) + vel;

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            dino <= '{y: coord_t'(GROUND_Y - DINO_H), ducking: 1'b0, airborne: 1'b0};
            vel  <= '0;
        end else if (restart) begin
            dino <= '{y: coord_t'(GROUND_Y - DINO_H), ducking: 1'b0, airborne: 1'b0};
            vel  <= '0;
        end else if (frame_run) begin
            if (on_ground) begin
                if (jump) begin
                    vel           <= -vel_t'(JUMP_VEL);
                    dino.y        <= dino.y - coord_t'(JUMP_VEL);
                    dino.ducking  <= 1'b0;
                    dino.airborne <= 1'b1;
                end else if (duck) begin
                    vel           <= '0;
                    dino.y        <= coord_t'(GROUND_Y - DUCK_H);  // Crouched sprite sits lower
                    dino.ducking  <= 1'b1;
                    dino.airborne <= 1'b0;
                end else begin
                    vel           <= '0;
                    dino.y        <= coord_t'(GROUND_Y - DINO_H);
                    dino.ducking  <= 1'b0;
                    dino.airborne <= 1'b0;
                end
            end else if (air_y >= $signed(12'(GROUND_Y - DINO_H))) begin
                // Landing clamp
                vel           <= '0;
                dino.y        <= coord_t'(GROUND_Y - DINO_H);
                dino.ducking  <= 1'b0;
                dino.airborne <= 1'b0;
            end else begin
                dino.y <= coord_t'(air_y);
                vel    <= vel + (duck ? vel_t'(FAST_FALL) : vel_t'(GRAVITY));  // Duck falls fast
            end
        end
    end

    // Clamp keeps the box above the ground for any mix of inputs
    a_y_floor: assert property (@(posedge pclk) disable iff (rst)
        dino.y <= coord_t'(GROUND_Y - DUCK_H));

endmodule

`default_nettype wire

//--- logic/game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_fsm import dino_pkg::*; (
    input  wire         pclk,
    input  wire         rst,
    input  wire         vsync,
    input  wire         start,
    input  wire         pause,
    input  wire         hit,
    output game_state_t state,
    output logic        frame_run,
    output logic        restart,
    output logic        game_over
);

    logic vsync_q;
    logic pause_q;
    logic pause_rise;

    assign pause_rise = pause && !pause_q;
    assign restart    = (state == ST_MENU) && start;  // Same edge as the move to run
    assign game_over  = (state == ST_OVER);

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            vsync_q   <= 1'b0;
            pause_q   <= 1'b0;
            frame_run <= 1'b0;
            state     <= ST_MENU;
        end else begin
            vsync_q   <= vsync;
            pause_q   <= pause;
            frame_run <= vsync && !vsync_q && (state == ST_RUN);  // One tick per frame
            case (state)
                ST_MENU:  if (start) state <= ST_RUN;
                ST_RUN: begin
                    if (pause_rise) state <= ST_PAUSE;  // Pause beats a hit
                    else if (hit)   state <= ST_OVER;
                end
                ST_PAUSE: if (pause_rise) state <= ST_RUN;
                ST_OVER:  if (start) state <= ST_MENU;
                default:  state <= ST_MENU;
            endcase
        end
    end

    a_state_legal: assert property (@(posedge pclk) disable iff (rst)
        state inside {ST_MENU, ST_RUN, ST_PAUSE, ST_OVER});

endmodule

`default_nettype wire

//--- logic/dino_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dino_regs import dino_pkg::*; (
    input  wire              pclk,
    input  wire              rst,
    input  wire wb_req_t     req,
    output wb_rsp_t          rsp,
    input  wire game_state_t state,
    input  wire dino_t       dino,
    input  wire score_t      score,
    input  wire xpos_t       obs0_x,
    output speed_t           speed
);

    logic        ack;
    logic [15:0] rd_dat;
    logic        req_seen;
    logic [15:0] status;

    assign req_seen = req.cyc && req.stb && !ack;  // Skips the cycle right after an ack

    // Read-back mux
    always_comb begin
        case (req.adr)
            REG_SPEED:  status = {12'd0, speed};
            REG_STATE:  status = {11'd0, dino.ducking, dino.airborne, state};
            REG_DINO_Y: status = {6'd0, dino.y};
            REG_SCORE:  status = {6'd0, score};
            REG_OBS0_X: status = {{3{obs0_x[12]}}, obs0_x};  // Sign extended
            default:    status = 16'd0;
        endcase
    end

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            ack   <= 1'b0;
            speed <= speed_t'(SPEED_DEFAULT);
        end else begin
            ack <= req_seen;
            if (req_seen && req.we && req.adr == REG_SPEED) begin
                speed <= req.dat[3:0];  // Upper bits dropped
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (req_seen && !req.we) begin
            rd_dat <= status;
        end
    end

    assign rsp = '{ack: ack, dat: rd_dat};

    // Ack answers a cycle the master drove on the previous clock
    a_ack_live: assert property (@(posedge pclk) disable iff (rst)
        ack |-> $past(req.cyc && req.stb));

    a_ack_single: assert property (@(posedge pclk) disable iff (rst)
        ack |=> !ack);

endmodule

`default_nettype wire

//--- logic/dino_pkg.sv
`default_nettype none

package dino_pkg;

    // Screen geometry in pixels
    localparam int GROUND_Y      = 350;
    localparam int DINO_X        = 160;
    localparam int DINO_W        = 34;
    localparam int DINO_H        = 40;
    localparam int DUCK_W        = 48;
    localparam int DUCK_H        = 38;
    localparam int DUCK_TOP_TRIM = 12;  // Hitbox top drops while ducking
    localparam int CACTUS_S_W    = 14;
    localparam int CACTUS_S_H    = 30;
    localparam int CACTUS_B_W    = 20;
    localparam int CACTUS_B_H    = 40;
    localparam int PTERO_W       = 36;
    localparam int PTERO_H       = 34;
    localparam int PTERO_LIFT    = 30;  // Flight height above ground

    // Per-frame physics
    localparam int JUMP_VEL      = 18;
    localparam int GRAVITY       = 1;
    localparam int FAST_FALL     = 3;

    localparam int SCREEN_W      = 640;
    localparam int SPAWN_X       = 640;
    localparam int START_X       = 630;
    localparam int RETIRE_X      = -40;
    localparam int MIN_GAP       = 300;
    localparam int OBS_SLOTS     = 3;
    localparam int SPEED_DEFAULT = 4;

    // Wishbone register map
    localparam logic [2:0] REG_SPEED  = 3'd0;
    localparam logic [2:0] REG_STATE  = 3'd1;
    localparam logic [2:0] REG_DINO_Y = 3'd2;
    localparam logic [2:0] REG_SCORE  = 3'd3;
    localparam logic [2:0] REG_OBS0_X = 3'd4;

    typedef logic        [9:0]  coord_t;
    typedef logic signed [12:0] xpos_t;   // Wide enough to leave the screen
    typedef logic signed [9:0]  vel_t;
    typedef logic        [9:0]  score_t;
    typedef logic        [3:0]  speed_t;

    // The two upper codes both fly
    typedef enum logic [1:0] {SMALL, BIG, PTERO, PTERO2} obs_kind_t;

    typedef enum logic [2:0] {
        ST_MENU  = 3'd0,
        ST_RUN   = 3'd2,
        ST_PAUSE = 3'd3,
        ST_OVER  = 3'd4
    } game_state_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        coord_t y;         // Top of the sprite box
        logic   ducking;
        logic   airborne;
    } dino_t;

    typedef struct packed {
        logic      active;
        obs_kind_t kind;
        xpos_t     x;
    } obs_slot_t;

    typedef obs_slot_t [OBS_SLOTS-1:0] obs_slots_t;

endpackage

`default_nettype wire
